// File: flist.f
source/audio_pkg.sv
source/sample_if.sv
source/credit_fifo.sv
source/mic_i2s_receiver.sv
source/tone_generator.sv
source/audio_mixer.sv
source/i2s_audio_out.sv
source/audio_lab_top.sv
bench/tb_clock_gen.sv
bench/tb_audio_lab.sv

// File: Makefile
VERILATOR ?= verilator
TOP       := tb_audio_lab
FLIST     := flist.f
VFLAGS    := --binary --timing -j 0 --timescale 1ns/100ps --top-module $(TOP)
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell cat $(FLIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then exit 1; fi
	@grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/tb_audio_lab.sv
module tb_audio_lab;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int sck_div      = 2;
    localparam int frame_cycles = 128 * sck_div;
    localparam int tone_amp     = 8192;

    logic       clk;
    logic       i_rst_n  = 1'b0;
    logic [1:0] i_key    = 2'd0;
    logic       i_mic_sd = 1'b0;
    logic       o_mic_sck;
    logic       o_mic_ws;
    logic       o_bclk;
    logic       o_lrclk;
    logic       o_sdata;
    logic       o_led_clip;

    logic [23:0] feed[$];        // Words of the current test
    logic [23:0] mic_queue[$];   // Words still to be played
    logic [15:0] rx_queue[$];    // Left words from the first non-zero frame on

    int checks   = 0;
    int errors   = 0;
    int timeouts = 0;

    tb_clock_gen u_clk (.o_clk(clk));

    audio_lab_top #(
        .sck_div        ( sck_div  ),
        .tone_amplitude ( tone_amp )
    ) uut (
        .clk        ( clk        ),
        .i_rst_n    ( i_rst_n    ),
        .i_key      ( i_key      ),
        .i_mic_sd   ( i_mic_sd   ),
        .o_mic_sck  ( o_mic_sck  ),
        .o_mic_ws   ( o_mic_ws   ),
        .o_bclk     ( o_bclk     ),
        .o_lrclk    ( o_lrclk    ),
        .o_sdata    ( o_sdata    ),
        .o_led_clip ( o_led_clip )
    );

    // --------------------
    // Microphone model

    int          mic_pos      = 0;
    logic        mic_prev_sck = 1'b0;
    logic        mic_prev_ws  = 1'b0;
    logic [23:0] mic_shift    = '0;

    always @(posedge clk) begin
        #2;
        if (!i_rst_n) begin
            mic_pos      = 0;
            mic_prev_sck = 1'b0;
            mic_prev_ws  = 1'b0;
            i_mic_sd     = 1'b0;
        end else begin
            if (mic_prev_sck && !o_mic_sck) begin   // Bits change on falling sck
                if (mic_prev_ws && !o_mic_ws)
                    mic_pos = 0;
                else
                    mic_pos = mic_pos + 1;
                if (!o_mic_ws && mic_pos == 1)
                    mic_shift = (mic_queue.size() > 0) ? mic_queue.pop_front() : '0;
                else if (!o_mic_ws && mic_pos <= 24)
                    mic_shift = mic_shift << 1;
                if (!o_mic_ws && mic_pos >= 1 && mic_pos <= 24)
                    i_mic_sd = mic_shift[23];   // MSB first
                else
                    i_mic_sd = 1'b0;
            end
            mic_prev_sck = o_mic_sck;
            mic_prev_ws  = o_mic_ws;
        end
    end

    // --------------------
    // DAC side capture

    int          cap_pos        = 0;
    logic        cap_prev_bclk  = 1'b0;
    logic        cap_prev_lrclk = 1'b0;
    logic        cap_started    = 1'b0;
    logic [15:0] cap_word       = '0;

    // DAC lines sampled on falling clk edges
    always @(negedge clk) begin
        if (!i_rst_n) begin
            cap_pos        = 0;
            cap_prev_bclk  = 1'b0;
            cap_prev_lrclk = 1'b0;
            cap_started    = 1'b0;
            cap_word       = '0;
        end else begin
            if (cap_prev_bclk && !o_bclk) begin
                if (cap_prev_lrclk && !o_lrclk)
                    cap_pos = 0;
                else
                    cap_pos = cap_pos + 1;
            end else if (!cap_prev_bclk && o_bclk && !o_lrclk
                         && cap_pos >= 1 && cap_pos <= 16) begin
                cap_word = {cap_word[14:0], o_sdata};
                if (cap_pos == 16) begin
                    if (cap_word != '0)
                        cap_started = 1'b1;   // Leading silence skipped
                    if (cap_started)
                        rx_queue.push_back(cap_word);
                end
            end
            cap_prev_bclk  = o_bclk;
            cap_prev_lrclk = o_lrclk;
        end
    end

    // --------------------
    // Reference model

    function automatic int tone_expected(input int key, input int k);
        int half;
        if (key == 0)
            return 0;
        half = 2 << key;   // 4, 8 or 16 samples
        return ((k / half) % 2 == 0) ? tone_amp : -tone_amp;
    endfunction

    function automatic int mix_expected(input logic [23:0] word, input int tone);
        int sum;
        sum = int'($signed(word[23:8])) + tone;
        if (sum > 32767)
            sum = 32767;
        else if (sum < -32768)
            sum = -32768;
        return sum;
    endfunction

    // --------------------
    // Helper tasks

    task automatic check_value(input string what, input logic signed [31:0] got,
                               input logic signed [31:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("Error at %0t: %s is %0d, expected %0d", $time, what, got, expected);
        end
    endtask

    task automatic check_outputs_low(input string when);
        check_value({when, " o_mic_sck"}, 32'(o_mic_sck), 0);
        check_value({when, " o_mic_ws"}, 32'(o_mic_ws), 0);
        check_value({when, " o_bclk"}, 32'(o_bclk), 0);
        check_value({when, " o_lrclk"}, 32'(o_lrclk), 0);
        check_value({when, " o_sdata"}, 32'(o_sdata), 0);
        check_value({when, " o_led_clip"}, 32'(o_led_clip), 0);
    endtask

    // Holds reset for four cycles and reloads the queues meanwhile
    task automatic start_test(input logic [1:0] key);
        @(posedge clk);
        #2;
        i_rst_n = 1'b0;
        i_key   = key;
        repeat (2) @(posedge clk);
        mic_queue.delete();
        rx_queue.delete();
        foreach (feed[i])
            mic_queue.push_back(feed[i]);
        repeat (2) @(posedge clk);
        #2;
        i_rst_n = 1'b1;
    endtask

    task automatic wait_for_words(input int count, input int limit);
        int cycles;
        cycles = 0;
        while (rx_queue.size() < count && cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        if (rx_queue.size() < count) begin
            timeouts++;
            $display("Timeout: only %0d of %0d output words arrived", rx_queue.size(), count);
        end
    endtask

    task automatic compare_words(input int key);
        int n;
        n = (rx_queue.size() < feed.size()) ? rx_queue.size() : feed.size();
        for (int k = 0; k < n; k++)
            check_value($sformatf("key %0d word %0d", key, k), int'($signed(rx_queue[k])),
                        mix_expected(feed[k], tone_expected(key, k)));
    endtask

    task automatic run_stream(input int key);
        start_test(2'(key));
        wait_for_words(feed.size(), (feed.size() + 8) * frame_cycles);
        #2;
        compare_words(key);
    endtask

    // --------------------
    // Directed tests

    task automatic test_reset_state();
        @(posedge clk);
        #2;
        i_rst_n = 1'b0;
        i_key   = 2'd1;
        repeat (2) @(posedge clk);
        #2;
        check_outputs_low("in reset");
        repeat (2) @(posedge clk);
        #2;
        i_rst_n = 1'b1;
        @(posedge clk);
        #2;
        check_outputs_low("after reset");
    endtask

    task automatic test_mic_passthrough();
        feed.delete();
        feed.push_back(24'h123456);
        feed.push_back(24'hfedcba);
        feed.push_back(24'h7fff00);
        feed.push_back(24'h800000);
        feed.push_back(24'h000100);
        feed.push_back(24'hffff00);
        feed.push_back(24'h5a5a5a);
        feed.push_back(24'ha5a5a5);
        feed.push_back(24'h010203);
        feed.push_back(24'hc0ffee);
        run_stream(0);
        check_value("clip after passthrough", 32'(o_led_clip), 0);
    endtask

    task automatic test_tone_shape();
        feed.delete();
        repeat (24) feed.push_back(24'h000500);
        run_stream(1);
        check_value("clip after tone shape", 32'(o_led_clip), 0);
    endtask

    task automatic test_key_selection();
        for (int key = 2; key <= 3; key++) begin
            feed.delete();
            repeat (40) feed.push_back(24'hfff600);   // Top half is -10
            run_stream(key);
            check_value($sformatf("clip after key %0d", key), 32'(o_led_clip), 0);
        end
    endtask

    task automatic test_saturation_clip();
        feed.delete();
        repeat (3) begin
            feed.push_back(24'h700000);
            feed.push_back(24'h7fff00);
            feed.push_back(24'h900000);
            feed.push_back(24'h800000);
        end
        run_stream(1);
        check_value("clip after overflow", 32'(o_led_clip), 1);
        repeat (2 * frame_cycles) @(posedge clk);
        #2;
        check_value("clip held", 32'(o_led_clip), 1);
        feed.delete();
        start_test(2'd0);
        check_value("clip after reset", 32'(o_led_clip), 0);
    endtask

    task automatic test_flow_control();
        feed.delete();
        feed.push_back(24'h123456);   // Non-zero start marks the stream
        repeat (199) feed.push_back(24'($urandom()));
        run_stream(1);
    endtask

    initial begin
        void'($urandom(32'h7619));
        test_reset_state();
        test_mic_passthrough();
        test_tone_shape();
        test_key_selection();
        test_saturation_clip();
        test_flow_control();
        $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

// File: bench/tb_clock_gen.sv
module tb_clock_gen #(
    parameter int half_period = 20
)
(
    output logic o_clk
);

    timeunit 1ns;
    timeprecision 100ps;

    initial o_clk = 1'b0;

    always #(half_period) o_clk = ~o_clk;   // 40 ns period

endmodule

// File: source/audio_lab_top.sv
module audio_lab_top
    import audio_pkg::*;
#(
    parameter int sck_div        = default_sck_div,
    parameter int credit_depth   = default_credit_depth,
    parameter int tone_amplitude = default_tone_amplitude
)
(
    input  logic       clk,
    input  logic       i_rst_n,

    input  logic [1:0] i_key,
    input  logic       i_mic_sd,

    output logic       o_mic_sck,
    output logic       o_mic_ws,

    output logic       o_bclk,     // BCK
    output logic       o_lrclk,    // LCK
    output logic       o_sdata,    // DIN

    output logic       o_led_clip
);

    // --------------------
    // Sample links

    sample_if #(.payload_t(mic_sample_t))   mic_if  ();
    sample_if #(.payload_t(audio_sample_t)) tone_if ();
    sample_if #(.payload_t(audio_sample_t)) mix_if  ();

    // --------------------
    // Blocks

    mic_i2s_receiver #(
        .sck_div      ( sck_div      ),
        .credit_depth ( credit_depth )
    ) u_mic (
        .clk     ( clk       ),
        .i_rst_n ( i_rst_n   ),
        .i_sd    ( i_mic_sd  ),
        .o_sck   ( o_mic_sck ),
        .o_ws    ( o_mic_ws  ),
        .mic_out ( mic_if    )
    );

    tone_generator #(
        .tone_amplitude ( tone_amplitude ),
        .credit_depth   ( credit_depth   )
    ) u_tone (
        .clk      ( clk     ),
        .i_rst_n  ( i_rst_n ),
        .i_key    ( i_key   ),
        .tone_out ( tone_if )
    );

    audio_mixer #(
        .credit_depth ( credit_depth )
    ) u_mixer (
        .clk     ( clk        ),
        .i_rst_n ( i_rst_n    ),
        .mic_in  ( mic_if     ),
        .tone_in ( tone_if    ),
        .mix_out ( mix_if     ),
        .o_clip  ( o_led_clip )
    );

    i2s_audio_out #(
        .sck_div      ( sck_div      ),
        .credit_depth ( credit_depth )
    ) u_audio_out (
        .clk      ( clk     ),
        .i_rst_n  ( i_rst_n ),
        .audio_in ( mix_if  ),
        .o_bclk   ( o_bclk  ),
        .o_lrclk  ( o_lrclk ),
        .o_sdata  ( o_sdata )
    );

endmodule

// File: source/i2s_audio_out.sv
module i2s_audio_out
    import audio_pkg::*;
#(
    parameter int sck_div      = default_sck_div,
    parameter int credit_depth = default_credit_depth
)
(
    input  logic       clk,
    input  logic       i_rst_n,

    sample_if.receiver audio_in,

    output logic       o_bclk,
    output logic       o_lrclk,
    output logic       o_sdata
);

    localparam int w_div = $clog2(sck_div + 1);

    logic [w_div - 1:0] div_cnt;
    logic               bclk;
    logic [5:0]         bit_cnt;
    logic               tick;
    logic               fall;
    logic               frame_start;
    audio_sample_t      fifo_data;
    logic               fifo_empty;
    logic [w_audio - 1:0] shreg;
    logic               sdata;

    credit_fifo #(
        .payload_t ( audio_sample_t ),
        .depth     ( credit_depth   )
    ) u_fifo (
        .clk     ( clk         ),
        .i_rst_n ( i_rst_n     ),
        .wr      ( audio_in    ),
        .i_pop   ( frame_start ),
        .o_data  ( fifo_data   ),
        .o_empty ( fifo_empty  )
    );

    // --------------------
    // Bit clock and LR clock

    assign tick = (div_cnt == w_div'(sck_div - 1));
    assign fall = tick && bclk;

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            div_cnt <= '0;
            bclk    <= 1'b0;
            bit_cnt <= '0;
        end else begin
            div_cnt <= tick ? '0 : div_cnt + 1'b1;
            if (tick)
                bclk <= ~bclk;
            if (fall)
                bit_cnt <= bit_cnt + 1'b1;
        end
    end

    // Falling edge that closes the right half opens the next frame
    assign frame_start = fall && (bit_cnt == 6'd63);

    // --------------------
    // Serializer

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            shreg <= '0;
            sdata <= 1'b0;
        end else if (frame_start) begin
            shreg <= fifo_empty ? '0 : fifo_data;   // Underrun sends silence
            sdata <= 1'b0;                          // Delay slot after LR edge
        end else if (fall) begin
            sdata <= shreg[w_audio - 1];            // MSB first, then zero pad
            shreg <= shreg << 1;
        end
    end

    assign o_bclk  = bclk;
    assign o_lrclk = bit_cnt[5];
    assign o_sdata = sdata;

endmodule

// File: source/audio_mixer.sv
module audio_mixer
    import audio_pkg::*;
#(
    parameter int credit_depth = default_credit_depth
)
(
    input  logic       clk,
    input  logic       i_rst_n,

    sample_if.receiver mic_in,
    sample_if.receiver tone_in,
    sample_if.sender   mix_out,

    output logic       o_clip
);

    localparam int w_credit = $clog2(credit_depth + 1);

    mic_sample_t             mic_data;
    audio_sample_t           tone_data;
    logic                    mic_empty;
    logic                    tone_empty;
    logic                    pop;
    logic signed [w_audio:0] sum;       // One guard bit
    logic                    overflow;
    logic [w_credit - 1:0]   credits;
    logic                    valid_q;
    audio_sample_t           data_q;
    logic                    clip_q;

    // --------------------
    // Input buffers

    credit_fifo #(
        .payload_t ( mic_sample_t ),
        .depth     ( credit_depth )
    ) u_mic_fifo (
        .clk     ( clk       ),
        .i_rst_n ( i_rst_n   ),
        .wr      ( mic_in    ),
        .i_pop   ( pop       ),
        .o_data  ( mic_data  ),
        .o_empty ( mic_empty )
    );

    credit_fifo #(
        .payload_t ( audio_sample_t ),
        .depth     ( credit_depth   )
    ) u_tone_fifo (
        .clk     ( clk        ),
        .i_rst_n ( i_rst_n    ),
        .wr      ( tone_in    ),
        .i_pop   ( pop        ),
        .o_data  ( tone_data  ),
        .o_empty ( tone_empty )
    );

    // Pairs leave together so the k-th mic word meets the k-th tone sample
    assign pop = !mic_empty && !tone_empty && (credits != '0);

    // --------------------
    // Saturating add

    assign sum = {mic_data[w_mic - 1], mic_data[w_mic - 1 -: w_audio]}
               + {tone_data[w_audio - 1], tone_data};

    // Guard bit disagrees with the sign bit on overflow
    assign overflow = (sum[w_audio] != sum[w_audio - 1]);

    always_ff @(posedge clk) begin
        if (pop) begin
            if (overflow)
                data_q <= sum[w_audio] ? audio_min : audio_max;
            else
                data_q <= audio_sample_t'(sum[w_audio - 1:0]);
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            credits <= w_credit'(credit_depth);
            valid_q <= 1'b0;
            clip_q  <= 1'b0;
        end else begin
            valid_q <= pop;
            if (pop && overflow)
                clip_q <= 1'b1;    // Sticky until reset
            case ({pop, mix_out.credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    assign mix_out.valid = valid_q;
    assign mix_out.data  = data_q;
    assign o_clip        = clip_q;

endmodule

// File: source/tone_generator.sv
module tone_generator
    import audio_pkg::*;
#(
    parameter int tone_amplitude = default_tone_amplitude,
    parameter int credit_depth   = default_credit_depth
)
(
    input  logic       clk,
    input  logic       i_rst_n,
    input  logic [1:0] i_key,

    sample_if.sender   tone_out
);

    localparam int            w_credit = $clog2(credit_depth + 1);
    localparam audio_sample_t amp_pos  = audio_sample_t'(tone_amplitude);
    localparam audio_sample_t amp_neg  = -amp_pos;

    logic [1:0]            key_q;
    logic [3:0]            half_m1;     // Half period minus one, in samples
    logic [3:0]            sample_cnt;
    logic                  level_pos;
    logic                  send;
    logic [w_credit - 1:0] credits;
    logic                  valid_q;
    audio_sample_t         data_q;

    always_comb begin
        case (key_q)
            2'd1:    half_m1 = 4'd3;
            2'd2:    half_m1 = 4'd7;
            default: half_m1 = 4'd15;   // Key 0 is silent anyway
        endcase
    end

    // Hold off for one cycle while a new key restarts the wave
    assign send = (credits != '0) && (i_key == key_q);

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            key_q      <= i_key;
            sample_cnt <= '0;
            level_pos  <= 1'b1;
            credits    <= w_credit'(credit_depth);
            valid_q    <= 1'b0;
        end else begin
            valid_q <= send;

            if (i_key != key_q) begin
                key_q      <= i_key;
                sample_cnt <= '0;
                level_pos  <= 1'b1;    // Restart on the positive half
            end else if (send) begin
                if (sample_cnt == half_m1) begin
                    sample_cnt <= '0;
                    level_pos  <= ~level_pos;
                end else begin
                    sample_cnt <= sample_cnt + 1'b1;
                end
            end

            case ({send, tone_out.credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (send)
            data_q <= (key_q == 2'd0) ? '0 : (level_pos ? amp_pos : amp_neg);
    end

    assign tone_out.valid = valid_q;
    assign tone_out.data  = data_q;

endmodule

// File: source/mic_i2s_receiver.sv
module mic_i2s_receiver
    import audio_pkg::*;
#(
    parameter int sck_div      = default_sck_div,
    parameter int credit_depth = default_credit_depth
)
(
    input  logic     clk,
    input  logic     i_rst_n,

    input  logic     i_sd,
    output logic     o_sck,
    output logic     o_ws,

    sample_if.sender mic_out
);

    localparam int w_div    = $clog2(sck_div + 1);
    localparam int w_credit = $clog2(credit_depth + 1);

    logic [w_div - 1:0]    div_cnt;
    logic                  sck;
    logic [5:0]            bit_cnt;   // 64 bit clocks per frame
    logic                  tick;
    logic                  rise;
    logic                  fall;
    logic [w_mic - 2:0]    shift;
    logic                  word_done;
    logic                  send;
    logic [w_credit - 1:0] credits;
    logic                  valid_q;
    mic_sample_t           data_q;

    // --------------------
    // Bit clock and word select

    assign tick = (div_cnt == w_div'(sck_div - 1));
    assign rise = tick && !sck;
    assign fall = tick && sck;

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            div_cnt <= '0;
            sck     <= 1'b0;
            bit_cnt <= '0;
        end else begin
            div_cnt <= tick ? '0 : div_cnt + 1'b1;
            if (tick)
                sck <= ~sck;
            if (fall)
                bit_cnt <= bit_cnt + 1'b1;  // Wraps at frame end
        end
    end

    assign o_sck = sck;
    assign o_ws  = bit_cnt[5];  // Low for left half

    // --------------------
    // Left word capture

    // MSB arrives one bit clock after ws falls, LSB at bit 24
    assign word_done = rise && (bit_cnt == 6'd24);
    assign send      = word_done && (credits != '0);  // No credit drops the word

    always_ff @(posedge clk) begin
        if (rise)
            shift <= {shift[w_mic - 3:0], i_sd};
        if (send)
            data_q <= mic_sample_t'({shift, i_sd});
    end

    // --------------------
    // Credits toward the mixer

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            credits <= w_credit'(credit_depth);
            valid_q <= 1'b0;
        end else begin
            valid_q <= send;
            case ({send, mic_out.credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    assign mic_out.valid = valid_q;
    assign mic_out.data  = data_q;

endmodule

// File: source/credit_fifo.sv
module credit_fifo
    import audio_pkg::*;
#(
    parameter type payload_t = audio_sample_t,
    parameter int  depth     = default_credit_depth
)
(
    input  logic       clk,
    input  logic       i_rst_n,

    sample_if.receiver wr,

    input  logic       i_pop,
    output payload_t   o_data,
    output logic       o_empty
);

    localparam int w_ptr = (depth > 1) ? $clog2(depth) : 1;
    localparam int w_cnt = $clog2(depth + 1);

    payload_t           mem [depth];
    logic [w_ptr - 1:0] wr_ptr;
    logic [w_ptr - 1:0] rd_ptr;
    logic [w_cnt - 1:0] count;
    logic               pop;

    function automatic logic [w_ptr - 1:0] next_ptr(input logic [w_ptr - 1:0] ptr);
        return (ptr == w_ptr'(depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign o_empty   = (count == '0);
    assign pop       = i_pop && !o_empty;   // Pop on empty is ignored
    assign o_data    = mem[rd_ptr];
    assign wr.credit = pop;                 // Slot goes back in the pop cycle

    // Credits keep the sender from writing into a full buffer
    always_ff @(posedge clk) begin
        if (wr.valid) begin
            mem[wr_ptr] <= wr.data;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr.valid)
                wr_ptr <= next_ptr(wr_ptr);
            if (pop)
                rd_ptr <= next_ptr(rd_ptr);

            case ({wr.valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: source/sample_if.sv
// Sample link with credit-based flow control
//
// The sender starts with as many credits as the receiver has slots.
// One valid cycle spends a credit and one credit pulse returns it.

interface sample_if
    import audio_pkg::*;
#(
    parameter type payload_t = audio_sample_t
);

    logic     valid;   // One sample this cycle
    payload_t data;
    logic     credit;  // One slot freed this cycle

    modport sender (
        output valid,
        output data,
        input  credit
    );

    modport receiver (
        input  valid,
        input  data,
        output credit
    );

endinterface

// File: source/audio_pkg.sv
package audio_pkg;

    // Sample widths
    localparam int w_mic   = 24;
    localparam int w_audio = 16;

    // --------------------
    // Sample types

    typedef logic signed [w_mic   - 1:0] mic_sample_t;    // INMP441 word
    typedef logic signed [w_audio - 1:0] audio_sample_t;  // DAC sample

    // --------------------
    // Saturation limits for the mixer

    localparam audio_sample_t audio_max = 16'sh7fff;
    localparam audio_sample_t audio_min = 16'sh8000;

    // --------------------
    // Defaults for the top-level parameters

    localparam int default_credit_depth   = 4;     // FIFO depth and initial credits
    localparam int default_sck_div        = 8;     // clk cycles per half bit clock
    localparam int default_tone_amplitude = 8192;

endpackage
